/* hw/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

  // Core word and fetch alignment
  localparam int unsigned XLEN   = 32;
  // Instructions are word aligned, low PC bits always zero
  localparam int unsigned OFFSET = 2;

  // Global history length, also the PHT index width
  localparam int unsigned HLEN      = 4;
  localparam int unsigned PHT_DEPTH = 2 ** HLEN;

  // BTB geometry
  localparam int unsigned BTB_BITS    = 4;
  localparam int unsigned BTB_DEPTH   = 2 ** BTB_BITS;
  localparam int unsigned BTB_TAG_LEN = XLEN - BTB_BITS - OFFSET;

  // Stored target drops the alignment bits
  localparam int unsigned TGT_LEN = XLEN - OFFSET;

  // Two-bit saturating counter states
  typedef enum logic [1:0] {
    SNT = 2'b00,
    WNT = 2'b01,
    WT  = 2'b10,
    ST  = 2'b11
  } c2b_t;

  // Counter state after reset or flush
  localparam c2b_t INIT_C2B = WNT;

  // PC as seen by the BTB
  typedef struct packed {
    logic [BTB_TAG_LEN-1:0] tag;
    logic [BTB_BITS-1:0]    idx;
    logic [OFFSET-1:0]      offset;
  } btb_view_t;

  // PC as seen by the gshare hash
  typedef struct packed {
    logic [XLEN-HLEN-OFFSET-1:0] unused;
    logic [HLEN-1:0]             hash;
    logic [OFFSET-1:0]           offset;
  } pht_view_t;

  // One PC word, split differently by each table
  typedef union packed {
    btb_view_t as_btb;
    pht_view_t as_pht;
  } pc_view_u;

  // Report from the branch unit once a branch resolves
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] target;
    logic            taken;
    logic            mispredict;
  } resolution_t;

  // Prediction handed back to fetch
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic            taken;
    logic [XLEN-1:0] target;
  } prediction_t;

endpackage

`default_nettype wire

/* hw/bpu_ctrl.sv */
`default_nettype none

module bpu_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         flush_i,
  input  logic [bpu_pkg::XLEN-1:0]     curr_pc_i,
  input  logic                         res_valid_i,
  input  bpu_pkg::resolution_t         res_i,
  input  logic                         pht_rd_taken_i,
  input  logic                         btb_hit_i,
  input  logic [bpu_pkg::TGT_LEN-1:0]  btb_target_i,
  output logic [bpu_pkg::HLEN-1:0]     pht_rd_idx_o,
  output logic [bpu_pkg::HLEN-1:0]     pht_wr_idx_o,
  output logic                         pht_wr_en_o,
  output logic                         pht_wr_taken_o,
  output logic                         btb_wr_en_o,
  output logic                         btb_del_en_o,
  output bpu_pkg::prediction_t         pred_o
);

  import bpu_pkg::*;

  // Global branch history, newest outcome in bit 0
  logic [HLEN-1:0] ghist_q;

  // Fetch PC and resolved PC seen through the gshare view
  pc_view_u rd_pc;
  pc_view_u wr_pc;

  // Mispredicted and actually not taken
  logic drop_entry;

  assign rd_pc = curr_pc_i;
  assign wr_pc = res_i.pc;

  // Both indices hash with the history as it stands this cycle
  assign pht_rd_idx_o = rd_pc.as_pht.hash ^ ghist_q;
  assign pht_wr_idx_o = wr_pc.as_pht.hash ^ ghist_q;

  // Every resolution trains its counter
  assign pht_wr_en_o    = res_valid_i;
  assign pht_wr_taken_o = res_i.taken;

  // Entry is stale when the branch fell through after a wrong guess
  assign drop_entry   = res_i.mispredict & ~res_i.taken;
  // Write and delete are mutually exclusive by construction
  assign btb_wr_en_o  = res_valid_i & ~drop_entry;
  assign btb_del_en_o = res_valid_i & drop_entry;

  // History shifts left, outcome enters at the bottom
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      ghist_q <= '0;
    end else if (res_valid_i) begin
      ghist_q <= {ghist_q[HLEN-2:0], res_i.taken};
    end
  end

  // Final prediction, purely combinational
  assign pred_o.pc     = curr_pc_i;
  // A taken guess without a known target is useless to fetch
  assign pred_o.taken  = pht_rd_taken_i & btb_hit_i;
  // Restore the alignment bits on the stored target
  assign pred_o.target = {btb_target_i, {OFFSET{1'b0}}};

endmodule

`default_nettype wire

/* hw/gshare_pht.sv */
`default_nettype none

module gshare_pht (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  logic [bpu_pkg::HLEN-1:0]  rd_idx_i,
  input  logic [bpu_pkg::HLEN-1:0]  wr_idx_i,
  input  logic                      wr_en_i,
  input  logic                      wr_taken_i,
  output logic                      rd_taken_o
);

  import bpu_pkg::*;

  // Counter array, one entry per hashed index
  c2b_t pht_q [PHT_DEPTH];

  // Current and next value of the counter being trained
  c2b_t upd_cur;
  c2b_t upd_nxt;

  assign upd_cur = pht_q[wr_idx_i];

  // One step toward the outcome, saturating at both ends
  always_comb begin
    upd_nxt = upd_cur;
    if (wr_taken_i) begin
      case (upd_cur)
        SNT:     upd_nxt = WNT;
        WNT:     upd_nxt = WT;
        WT:      upd_nxt = ST;
        default: upd_nxt = ST;
      endcase
    end else begin
      case (upd_cur)
        ST:      upd_nxt = WT;
        WT:      upd_nxt = WNT;
        WNT:     upd_nxt = SNT;
        default: upd_nxt = SNT;
      endcase
    end
  end

  // Whole table returns to the weak state on reset or flush
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      for (int i = 0; i < PHT_DEPTH; i++) begin
        pht_q[i] <= INIT_C2B;
      end
    end else if (wr_en_i) begin
      pht_q[wr_idx_i] <= upd_nxt;
    end
  end

  // Taken states are the upper half, so the MSB decides
  assign rd_taken_o = pht_q[rd_idx_i][1];

endmodule

`default_nettype wire

/* hw/btb.sv */
`default_nettype none

module btb (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         flush_i,
  input  logic [bpu_pkg::XLEN-1:0]     curr_pc_i,
  input  logic                         wr_en_i,
  input  logic                         del_en_i,
  input  logic [bpu_pkg::XLEN-1:0]     res_pc_i,
  input  logic [bpu_pkg::TGT_LEN-1:0]  res_target_i,
  output logic                         hit_o,
  output logic [bpu_pkg::TGT_LEN-1:0]  target_o
);

  import bpu_pkg::*;

  // Per-entry valid bit, tag and word target
  logic [BTB_DEPTH-1:0]   valid_q;
  logic [BTB_TAG_LEN-1:0] tag_q    [BTB_DEPTH];
  logic [TGT_LEN-1:0]     target_q [BTB_DEPTH];

  // Both PCs decoded through the BTB view
  pc_view_u lkp_pc;
  pc_view_u res_pc;

  logic [BTB_BITS-1:0] lkp_idx;
  logic [BTB_BITS-1:0] res_idx;

  // Stored tag belongs to the resolved branch
  logic res_tag_match;

  assign lkp_pc  = curr_pc_i;
  assign res_pc  = res_pc_i;
  assign lkp_idx = lkp_pc.as_btb.idx;
  assign res_idx = res_pc.as_btb.idx;

  assign res_tag_match = (tag_q[res_idx] == res_pc.as_btb.tag);

  // Lookup is combinational, direct mapped
  assign hit_o    = valid_q[lkp_idx] & (tag_q[lkp_idx] == lkp_pc.as_btb.tag);
  assign target_o = target_q[lkp_idx];

  // Valid bits
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[res_idx] <= 1'b1;
    end else if (del_en_i && res_tag_match) begin
      // An aliasing branch keeps its entry
      valid_q[res_idx] <= 1'b0;
    end
  end

  // Tag and target payload
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_q[res_idx]    <= res_pc.as_btb.tag;
      target_q[res_idx] <= res_target_i;
    end
  end

endmodule

`default_nettype wire

/* hw/bpu.sv */
`default_nettype none

module bpu (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  logic [bpu_pkg::XLEN-1:0]  curr_pc_i,
  input  logic                      res_valid_i,
  input  bpu_pkg::resolution_t      res_i,
  output bpu_pkg::prediction_t      pred_o
);

  import bpu_pkg::*;

  // Control to PHT
  logic [HLEN-1:0] pht_rd_idx;
  logic [HLEN-1:0] pht_wr_idx;
  logic            pht_wr_en;
  logic            pht_wr_taken;
  logic            pht_rd_taken;

  // Control to BTB and back
  logic               btb_wr_en;
  logic               btb_del_en;
  logic               btb_hit;
  logic [TGT_LEN-1:0] btb_target;

  bpu_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .curr_pc_i      (curr_pc_i),
    .res_valid_i    (res_valid_i),
    .res_i          (res_i),
    .pht_rd_taken_i (pht_rd_taken),
    .btb_hit_i      (btb_hit),
    .btb_target_i   (btb_target),
    .pht_rd_idx_o   (pht_rd_idx),
    .pht_wr_idx_o   (pht_wr_idx),
    .pht_wr_en_o    (pht_wr_en),
    .pht_wr_taken_o (pht_wr_taken),
    .btb_wr_en_o    (btb_wr_en),
    .btb_del_en_o   (btb_del_en),
    .pred_o         (pred_o)
  );

  gshare_pht u_pht (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .flush_i    (flush_i),
    .rd_idx_i   (pht_rd_idx),
    .wr_idx_i   (pht_wr_idx),
    .wr_en_i    (pht_wr_en),
    .wr_taken_i (pht_wr_taken),
    .rd_taken_o (pht_rd_taken)
  );

  // Target stored without its alignment bits
  btb u_btb (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .curr_pc_i    (curr_pc_i),
    .wr_en_i      (btb_wr_en),
    .del_en_i     (btb_del_en),
    .res_pc_i     (res_i.pc),
    .res_target_i (res_i.target[XLEN-1:OFFSET]),
    .hit_o        (btb_hit),
    .target_o     (btb_target)
  );

endmodule

`default_nettype wire

/* dv/bpu_chk.sv */
`default_nettype none

module bpu_chk (
  input logic clk_i,
  input logic rst_i,
  input logic flush_i,
  input logic res_valid_i,
  input logic pht_wr_en_i,
  input logic btb_wr_en_i,
  input logic btb_del_en_i,
  input logic pred_taken_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // BTB write and delete are exclusive
  a_wr_del_excl: assert property (@(posedge clk_i) !(btb_wr_en_i && btb_del_en_i))
    else $error("BTB write and delete enables high in the same cycle");

  // All valids clear, so nothing can predict taken
  a_quiet_after_clear: assert property (@(posedge clk_i) (rst_i || flush_i) |=> !pred_taken_i)
    else $error("Prediction taken in the cycle after reset or flush");

  // No table write without a resolution strobe
  a_no_idle_write: assert property (@(posedge clk_i)
    !res_valid_i |-> !(pht_wr_en_i || btb_wr_en_i || btb_del_en_i))
    else $error("Table write enable high with no resolution strobe");

endmodule

bind bpu_ctrl bpu_chk u_chk (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .flush_i      (flush_i),
  .res_valid_i  (res_valid_i),
  .pht_wr_en_i  (pht_wr_en_o),
  .btb_wr_en_i  (btb_wr_en_o),
  .btb_del_en_i (btb_del_en_o),
  .pred_taken_i (pred_o.taken)
);

`default_nettype wire

/* dv/bpu_tb.sv */
`default_nettype none

module bpu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import bpu_pkg::*;

  localparam time         CLK_PERIOD     = 40ns;
  localparam time         DRIVE_SKEW     = 2ns;
  localparam int unsigned RST_CYCLES     = 2;
  localparam int unsigned NUM_CYCLES     = 600;
  localparam int unsigned FLUSH_A        = 180;
  localparam int unsigned FLUSH_B        = 410;
  localparam int unsigned TIMEOUT_CYCLES = 800;
  localparam time         RUN_LIMIT      = 32000ns;
  localparam logic [15:0] LFSR_SEED      = 16'd11862;
  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [15:0] LFSR_TAPS      = 16'hB400;

  logic            clk_i;
  logic            rst_i;
  logic            flush_i;
  logic [XLEN-1:0] curr_pc_i;
  logic            res_valid_i;
  resolution_t     res_i;
  prediction_t     pred_o;

  // Reference model state
  logic [HLEN-1:0]        m_hist;
  logic [1:0]             m_pht [PHT_DEPTH];
  logic [BTB_DEPTH-1:0]   m_valid;
  logic [BTB_TAG_LEN-1:0] m_tag [BTB_DEPTH];
  logic [XLEN-1:0]        m_tgt [BTB_DEPTH];

  logic [15:0] lfsr_q;
  string       test_name;
  int unsigned cycle;

  bpu DUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .curr_pc_i   (curr_pc_i),
    .res_valid_i (res_valid_i),
    .res_i       (res_i),
    .pred_o      (pred_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk_i = ~clk_i;
    end
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ LFSR_TAPS;
    end
    return n;
  endfunction

  // One LFSR step per bit drawn
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // Small PC pool, pairs share a BTB index with different tags
  function automatic logic [XLEN-1:0] pool_pc(input logic [2:0] sel);
    case (sel)
      3'd0:    return 32'h0000_1000;
      3'd1:    return 32'h0000_2000;
      3'd2:    return 32'h0000_1004;
      3'd3:    return 32'h0000_3044;
      3'd4:    return 32'h0000_0010;
      3'd5:    return 32'h8000_0010;
      3'd6:    return 32'h0000_103C;
      default: return 32'h0000_203C;
    endcase
  endfunction

  function automatic logic [HLEN-1:0] hash_of(input logic [XLEN-1:0] pc);
    return pc[OFFSET +: HLEN];
  endfunction

  function automatic logic [BTB_BITS-1:0] idx_of(input logic [XLEN-1:0] pc);
    return pc[OFFSET +: BTB_BITS];
  endfunction

  function automatic logic [BTB_TAG_LEN-1:0] tag_of(input logic [XLEN-1:0] pc);
    return pc[XLEN-1 -: BTB_TAG_LEN];
  endfunction

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic value_error(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    $display("** Error: test %s, %s expected 0x%08h, actual 0x%08h",
             test_name, field, exp, act);
    abort_run();
  endtask

  // Zero history, weak counters, no valid BTB entry
  task automatic model_reset();
    m_hist  = '0;
    m_valid = '0;
    for (int i = 0; i < PHT_DEPTH; i++) begin
      m_pht[i] = INIT_C2B;
    end
  endtask

  // Mirrors what the DUT took in at the edge just passed
  task automatic model_update();
    logic [HLEN-1:0]     pi;
    logic [BTB_BITS-1:0] bi;
    if (rst_i || flush_i) begin
      model_reset();
    end else if (res_valid_i) begin
      // Train index uses the history before the shift
      pi = hash_of(res_i.pc) ^ m_hist;
      bi = idx_of(res_i.pc);
      if (res_i.taken && m_pht[pi] != 2'b11) begin
        m_pht[pi] = m_pht[pi] + 2'd1;
      end else if (!res_i.taken && m_pht[pi] != 2'b00) begin
        m_pht[pi] = m_pht[pi] - 2'd1;
      end
      if (res_i.mispredict && !res_i.taken) begin
        // Delete only hits the branch that owns the entry
        if (m_tag[bi] == tag_of(res_i.pc)) begin
          m_valid[bi] = 1'b0;
        end
      end else begin
        m_valid[bi] = 1'b1;
        m_tag[bi]   = tag_of(res_i.pc);
        m_tgt[bi]   = {res_i.target[XLEN-1:OFFSET], {OFFSET{1'b0}}};
      end
      m_hist = {m_hist[HLEN-2:0], res_i.taken};
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    // Initial value already covers the first edge
    rst_i   = (cycle + 1 < RST_CYCLES);
    flush_i = (cycle == FLUSH_A) || (cycle == FLUSH_B);
    r = rand_bits(3);
    curr_pc_i = pool_pc(r[2:0]);
    // Resolution about three cycles in four
    r = rand_bits(2);
    res_valid_i = !rst_i && (r[1:0] != 2'b00);
    r = rand_bits(3);
    res_i.pc = pool_pc(r[2:0]);
    // Biased toward taken so counters reach saturation
    r = rand_bits(2);
    res_i.taken = (r[1:0] != 2'b00);
    r = rand_bits(1);
    res_i.mispredict = r[0];
    r = rand_bits(30);
    res_i.target = {r[29:0], 2'b00};
  endtask

  task automatic check_pred();
    logic [BTB_BITS-1:0] bi;
    logic [HLEN-1:0]     pi;
    logic                hit;
    logic                exp_taken;
    bi        = idx_of(curr_pc_i);
    pi        = hash_of(curr_pc_i) ^ m_hist;
    hit       = m_valid[bi] && (m_tag[bi] == tag_of(curr_pc_i));
    exp_taken = m_pht[pi][1] && hit;
    assert (pred_o.pc === curr_pc_i)
      else value_error("pred.pc", curr_pc_i, pred_o.pc);
    assert (pred_o.taken === exp_taken)
      else value_error("pred.taken", {31'd0, exp_taken}, {31'd0, pred_o.taken});
    // Target only means something on a BTB hit
    if (hit) begin
      assert (pred_o.target === m_tgt[bi])
        else value_error("pred.target", m_tgt[bi], pred_o.target);
    end
  endtask

  initial begin : stimulus
    lfsr_q      = LFSR_SEED;
    rst_i       = 1'b1;
    flush_i     = 1'b0;
    curr_pc_i   = '0;
    res_valid_i = 1'b0;
    res_i       = '0;
    test_name   = "after_reset";
    for (int i = 0; i < BTB_DEPTH; i++) begin
      m_tag[i] = '0;
      m_tgt[i] = '0;
    end
    model_reset();
    cycle = 0;
    while (cycle < NUM_CYCLES) begin
      if ($time > RUN_LIMIT) begin
        $display("Main loop ran past its time limit at cycle %0d", cycle);
        abort_run();
      end
      @(posedge clk_i);
      model_update();
      #(DRIVE_SKEW);
      drive_inputs();
      if (cycle < 20) begin
        test_name = "after_reset";
      end else if ((cycle > FLUSH_A && cycle <= FLUSH_A + 10) ||
                   (cycle > FLUSH_B && cycle <= FLUSH_B + 10)) begin
        test_name = "after_flush";
      end else begin
        test_name = "random_traffic";
      end
      // Sample just before the next edge
      #(CLK_PERIOD - 2 * DRIVE_SKEW);
      check_pred();
      cycle++;
    end
    $display("All checks passed");
    $finish;
  end

  initial begin : watchdog
    for (int unsigned i = 0; i < TIMEOUT_CYCLES; i++) begin
      @(posedge clk_i);
    end
    $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
    abort_run();
  end

endmodule

`default_nettype wire

/* tb.f */
hw/bpu_pkg.sv
hw/bpu_ctrl.sv
hw/gshare_pht.sv
hw/btb.sv
hw/bpu.sv
dv/bpu_chk.sv
dv/bpu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the BPU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module bpu_tb -f tb.f -o bpu_sim

# Exit status of the model is the test verdict
./obj_dir/bpu_sim
